// ==== test/simple_processor_patterns.txt ====
// Columns: test, instruction word, idle cycles after it, expect flag, expected rd, expected data
// Instruction word: func[18:15] rd[14:12] rs1[11:9] rs2[8:6] imm[5:0], all values hex
01 094C0 0 1 1 00000000  // ADD  r1, r2, r3 right after reset
01 02015 0 1 2 00000015  // ADDI r2, r0, 21
01 0303B 0 1 3 FFFFFFFB  // ADDI r3, r0, -5
01 04020 0 1 4 FFFFFFE0  // ADDI r4, r0, -32
02 0100C 0 1 1 0000000C  // ADDI r1, r0, 12
02 02036 0 1 2 FFFFFFF6  // ADDI r2, r0, -10
02 0B280 0 1 3 00000002  // ADD  r3, r1, r2
02 14280 0 1 4 00000016  // SUB  r4, r1, r2
02 15440 0 1 5 FFFFFFEA  // SUB  r5, r2, r1
02 1E280 0 1 6 00000004  // AND  r6, r1, r2
02 27280 0 1 7 FFFFFFFE  // OR   r7, r1, r2
02 2B280 0 1 3 FFFFFFFA  // XOR  r3, r1, r2
02 34200 0 1 4 FFFFFFF3  // NOT  r4, r1
03 0100B 0 1 1 0000000B  // ADDI r1, r0, 11
03 02004 0 1 2 00000004  // ADDI r2, r0, 4
03 3B280 0 1 3 000000B0  // SLL  r3, r1, r2
03 4C680 0 1 4 0000000B  // SLR  r4, r3, r2
03 4521C 0 1 5 B0000000  // SLLI r5, r1, 28
03 56A1F 0 1 6 00000001  // SLRI r6, r5, 31
03 42403 0 1 2 00000020  // SLLI r2, r2, 3 gives 32
03 4CA80 0 1 4 00000000  // SLR  r4, r5, r2 by 32
03 4723F 0 1 7 00000000  // SLLI r7, r1, -1 is a huge amount
04 01008 0 1 1 00000008  // ADDI r1, r0, 8
04 02039 0 1 2 FFFFFFF9  // ADDI r2, r0, -7
04 60280 0 0 0 00000000  // STORE [r1] = r2
04 5B200 1 1 3 FFFFFFF9  // LOAD r3, [r1]
04 0401C 0 1 4 0000001C  // ADDI r4, r0, 28
04 60840 0 0 0 00000000  // STORE [r4] = r1
04 5D800 1 1 5 00000008  // LOAD r5, [r4]
05 01005 0 1 1 00000005  // ADDI r1, r0, 5
05 0A240 0 1 2 0000000A  // ADD  r2, r1, r1
05 0B440 0 1 3 0000000F  // ADD  r3, r2, r1
05 14680 0 1 4 00000005  // SUB  r4, r3, r2
05 600C0 0 0 0 00000000  // STORE [r0] = r3
05 5D000 1 1 5 0000000F  // LOAD r5, [r0]
05 0EB40 0 1 6 0000001E  // ADD  r6, r5, r5 two cycles after the LOAD
05 2FD40 0 1 7 00000011  // XOR  r7, r6, r5
06 69240 0 0 0 00000000  // Code 13 aimed at r1
06 72480 0 0 0 00000000  // Code 14 aimed at r2
06 7B6C0 0 0 0 00000000  // Code 15 aimed at r3
06 0C200 0 1 4 00000005  // ADD  r4, r1, r0 shows r1 untouched

// ==== files.f ====
+incdir+include
rtl/simple_processor_pkg.sv
rtl/register_file.sv
rtl/data_memory.sv
rtl/merge_execution.sv
rtl/instr_issue.sv
rtl/simple_processor.sv
test/tb_simple_processor.sv

// ==== Bender.yml ====
package:
  name: simple_processor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/simple_processor_pkg.sv
      - rtl/register_file.sv
      - rtl/data_memory.sv
      - rtl/merge_execution.sv
      - rtl/instr_issue.sv
      - rtl/simple_processor.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_simple_processor.sv

// ==== test/tb_simple_processor.sv ====
/*
  Self-checking testbench for the simple processor datapath.
  Replays instruction words from the pattern file and compares each
  writeback strobe, in order, with the expected register and value.
*/

`timescale 1ns/1ps
`default_nettype none

`include "simple_processor_config.svh"

module tb_simple_processor
  import simple_processor_pkg::*;
();

  localparam int CLK_PERIOD   = 20;   // ns
  localparam int RESET_CYCLES = 5;
  localparam int FIELDS       = 6;    // Words per pattern record
  localparam int MAX_RECORDS  = 64;
  localparam int DRAIN_LIMIT  = 8;    // Cycles allowed for pending writebacks
  localparam int QUIET_CYCLES = 3;    // LOAD writeback latency, stray strobes show up here

  // DUT ports
  logic                       clk_i;
  logic                       rst_n_i;
  logic                       instr_valid_i;
  logic [`SP_INSTR_WIDTH-1:0] instr_i;
  logic                       wb_valid_o;
  reg_idx_t                   wb_idx_o;
  logic [`SP_DATA_WIDTH-1:0]  wb_data_o;

  // Pattern records: test, instr, idle, expect, idx, data
  logic [31:0]                pat_mem [FIELDS*MAX_RECORDS];
  reg_idx_t                   exp_idx_q [$];    // Expected writebacks, oldest first
  logic [`SP_DATA_WIDTH-1:0]  exp_data_q [$];
  int                         num_records;
  int                         cycle_limit;      // Zero until the patterns are loaded
  int                         cycle_count;
  int                         pass_count;
  int                         fail_count;
  int                         group_checks;     // Per test group
  int                         group_errors;

  simple_processor dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_idx_o      (wb_idx_o),
    .wb_data_o     (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Writeback monitor, outputs are registered so stable here
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : check_writeback
    reg_idx_t                  exp_idx;
    logic [`SP_DATA_WIDTH-1:0] exp_data;
    logic                      mismatch;
    if (rst_n_i && wb_valid_o) begin
      if (exp_idx_q.size() == 0) begin
        $display("Unexpected writeback strobe to r%0d with data %08h at %0t ns",
                 wb_idx_o, wb_data_o, $time);
        fail_count++;
        group_errors++;
      end else begin
        exp_idx  = exp_idx_q.pop_front();
        exp_data = exp_data_q.pop_front();
        mismatch = 1'b0;
        group_checks++;
        if (wb_idx_o !== exp_idx) begin
          $display("Fail at %0t ns: wb_idx_o expected %0d, got %0d", $time, exp_idx, wb_idx_o);
          mismatch = 1'b1;
        end
        if (wb_data_o !== exp_data) begin
          $display("Fail at %0t ns: wb_data_o expected %08h, got %08h",
                   $time, exp_data, wb_data_o);
          mismatch = 1'b1;
        end
        if (mismatch) begin
          fail_count++;
          group_errors++;
        end else begin
          pass_count++;
        end
      end
    end
  end

  // Cycle watchdog, limit is four times the pattern length
  initial begin : watchdog
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // One strobe on a falling edge, then the record's idle cycles
  task automatic issue_record(input int rec);
    int base;
    base          = rec * FIELDS;
    instr_valid_i = 1'b1;
    instr_i       = pat_mem[base+1][`SP_INSTR_WIDTH-1:0];
    if (pat_mem[base+3] != 0) begin
      exp_idx_q.push_back(reg_idx_t'(pat_mem[base+4]));
      exp_data_q.push_back(pat_mem[base+5]);
    end
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    instr_i       = '0;
    repeat (pat_mem[base+2]) @(negedge clk_i);
  endtask

  // Drain the pipeline, report leftovers and the group summary
  task automatic finish_group(input int test_num);
    int waited;
    waited = 0;
    while (exp_idx_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    repeat (QUIET_CYCLES) @(posedge clk_i);
    if (exp_idx_q.size() != 0) begin
      $display("Test %0d: %0d expected writeback strobe(s) never arrived",
               test_num, exp_idx_q.size());
      fail_count   += exp_idx_q.size();
      group_errors += exp_idx_q.size();
      exp_idx_q.delete();
      exp_data_q.delete();
    end
    $display("Test %0d done: %0d writebacks checked, %0d errors",
             test_num, group_checks, group_errors);
    group_checks = 0;
    group_errors = 0;
    @(negedge clk_i);                              // Realign for the next strobe
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : run_patterns
    int rec;
    int cur_test;
    int cycle_total;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pass_count    = 0;
    fail_count    = 0;
    group_checks  = 0;
    group_errors  = 0;
    num_records   = 0;
    cycle_limit   = 0;
    cycle_total   = 0;

    $readmemh("test/simple_processor_patterns.txt", pat_mem);
    // Records stop at the first empty or zero test number
    while (num_records < MAX_RECORDS && !$isunknown(pat_mem[num_records*FIELDS]) &&
           pat_mem[num_records*FIELDS] != 0) begin
      cycle_total += 1 + pat_mem[num_records*FIELDS+2];
      num_records++;
    end
    cycle_limit = 4 * cycle_total;
    if (num_records == 0) begin
      $display("No pattern records found in the pattern file");
      fail_count++;
    end

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    rec = 0;
    while (rec < num_records) begin
      cur_test = pat_mem[rec*FIELDS];
      issue_record(rec);
      rec++;
      if (rec == num_records || pat_mem[rec*FIELDS] != cur_test) begin
        finish_group(cur_test);                    // Group ends on a new test number
      end
    end

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/simple_processor.sv ====
/*
  Top level of the single-issue datapath: one host instruction per strobe,
  results reported on the writeback strobe. Instances and wiring only.
*/

`timescale 1ns/1ps
`default_nettype none

`include "simple_processor_config.svh"

module simple_processor
  import simple_processor_pkg::*;
(
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       instr_valid_i,  // One instruction per strobe
  input  wire [`SP_INSTR_WIDTH-1:0] instr_i,
  output logic                      wb_valid_o,     // Register written
  output reg_idx_t                  wb_idx_o,
  output logic [`SP_DATA_WIDTH-1:0] wb_data_o
);

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////

  reg_idx_t                  rs1_idx, rs2_idx;
  logic [`SP_DATA_WIDTH-1:0] rs1_data, rs2_data;       // Register file reads
  logic                      ex_valid;
  func_t                     func;
  logic [`SP_IMM_WIDTH-1:0]  imm;
  logic [`SP_DATA_WIDTH-1:0] op_a, op_b, rd_data;      // Execute operands and result
  logic                      dmem_req, dmem_we, dmem_ack;
  logic [`SP_DATA_WIDTH-1:0] dmem_addr, dmem_wdata, dmem_rdata;

  instr_issue u_issue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .ex_valid_o    (ex_valid),
    .func_o        (func),
    .imm_o         (imm),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .rd_data_i     (rd_data),
    .dmem_ack_i    (dmem_ack),
    .wb_valid_o    (wb_valid_o),
    .wb_idx_o      (wb_idx_o),
    .wb_data_o     (wb_data_o)
  );

  // Write port fed by the registered writeback
  register_file u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_valid_o),
    .wr_idx_i   (wb_idx_o),
    .wr_data_i  (wb_data_o)
  );

  merge_execution u_exec (
    .clk_i        (clk_i),
    .ex_valid_i   (ex_valid),
    .func_i       (func),
    .rs1_data_i   (op_a),
    .rs2_data_i   (op_b),
    .imm_i        (imm),
    .dmem_rdata_i (dmem_rdata),
    .dmem_ack_i   (dmem_ack),
    .dmem_req_o   (dmem_req),
    .dmem_we_o    (dmem_we),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .rd_data_o    (rd_data)
  );

  data_memory u_dmem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (dmem_req),
    .we_i    (dmem_we),
    .addr_i  (dmem_addr),
    .wdata_i (dmem_wdata),
    .rdata_o (dmem_rdata),
    .ack_o   (dmem_ack)
  );

endmodule

`default_nettype wire

// ==== rtl/instr_issue.sv ====
/*
  Issue stage: splits the instruction word, captures operands on a strobe,
  tracks the extra LOAD cycle and registers the writeback.
  The writeback registers also drive the register file write port.
*/

`timescale 1ns/1ps
`default_nettype none

`include "simple_processor_config.svh"

module instr_issue
  import simple_processor_pkg::*;
(
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       instr_valid_i,  // Host strobe
  input  wire [`SP_INSTR_WIDTH-1:0] instr_i,        // Instruction word
  output reg_idx_t                  rs1_idx_o,      // Register file read indices
  output reg_idx_t                  rs2_idx_o,
  input  wire [`SP_DATA_WIDTH-1:0]  rs1_data_i,     // Register file read data
  input  wire [`SP_DATA_WIDTH-1:0]  rs2_data_i,
  output logic                      ex_valid_o,     // Execute cycle strobe
  output func_t                     func_o,
  output logic [`SP_IMM_WIDTH-1:0]  imm_o,
  output logic [`SP_DATA_WIDTH-1:0] op_a_o,
  output logic [`SP_DATA_WIDTH-1:0] op_b_o,
  input  wire [`SP_DATA_WIDTH-1:0]  rd_data_i,      // Result from execute
  input  wire                       dmem_ack_i,     // Load data is ready
  output logic                      wb_valid_o,     // Writeback strobe
  output reg_idx_t                  wb_idx_o,
  output logic [`SP_DATA_WIDTH-1:0] wb_data_o
);

  localparam int IDX_W    = $bits(reg_idx_t);
  localparam int RS2_LSB  = `SP_IMM_WIDTH;
  localparam int RS1_LSB  = RS2_LSB + IDX_W;
  localparam int RD_LSB   = RS1_LSB + IDX_W;
  localparam int FUNC_LSB = RD_LSB + IDX_W;

  ////////////////////////////////////////////////////////////
  // Field split
  ////////////////////////////////////////////////////////////

  func_t    instr_func;
  reg_idx_t instr_rd;
  logic     ex_valid_q, load_wait_q;  // Control state
  func_t    func_q;
  reg_idx_t rd_q;                     // Destination of the executing op
  logic     is_alu, wr_now;           // ALU or shift op / result ready now

  assign instr_func = func_t'(instr_i[FUNC_LSB +: 4]);
  assign instr_rd   = instr_i[RD_LSB +: IDX_W];
  assign rs1_idx_o  = instr_i[RS1_LSB +: IDX_W];
  assign rs2_idx_o  = instr_i[RS2_LSB +: IDX_W];

  ////////////////////////////////////////////////////////////
  // Writeback decision
  ////////////////////////////////////////////////////////////

  assign is_alu = func_q inside {[ADDI:SLRI]};                   // Codes 0 to 10
  assign wr_now = (ex_valid_q && is_alu) || (load_wait_q && dmem_ack_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_q  <= 1'b0;
      load_wait_q <= 1'b0;
      func_q      <= ADDI;
      wb_valid_o  <= 1'b0;
    end else begin
      ex_valid_q  <= instr_valid_i;
      load_wait_q <= ex_valid_q && (func_q == LOAD);             // Second LOAD cycle
      wb_valid_o  <= wr_now;
      if (instr_valid_i) func_q <= instr_func;
    end
  end

  // Operand capture. A result finishing this cycle is newer than the register file
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      rd_q   <= instr_rd;
      imm_o  <= instr_i[`SP_IMM_WIDTH-1:0];
      op_a_o <= (wr_now && (rd_q == rs1_idx_o)) ? rd_data_i : rs1_data_i;
      op_b_o <= (wr_now && (rd_q == rs2_idx_o)) ? rd_data_i : rs2_data_i;
    end
    if (wr_now) begin
      wb_idx_o  <= rd_q;
      wb_data_o <= rd_data_i;
    end
  end

  assign ex_valid_o = ex_valid_q;
  assign func_o     = load_wait_q ? LOAD : func_q;               // Keep load data selected

endmodule

`default_nettype wire

// ==== rtl/merge_execution.sv ====
/*
  Combinational execution unit: arithmetic, logic, shift and memory paths
  merged onto one result bus selected by the function code.
  Memory requests go out only in the execute cycle of LOAD and STORE.
*/

`timescale 1ns/1ps
`default_nettype none

`include "simple_processor_config.svh"

module merge_execution
  import simple_processor_pkg::*;
(
  input  wire                       clk_i,          // Not used, combinational unit
  input  wire                       ex_valid_i,     // Execute cycle of a new instruction
  input  wire func_t                func_i,         // Function code
  input  wire [`SP_DATA_WIDTH-1:0]  rs1_data_i,     // First operand, memory address
  input  wire [`SP_DATA_WIDTH-1:0]  rs2_data_i,     // Second operand, store data
  input  wire [`SP_IMM_WIDTH-1:0]   imm_i,          // Signed immediate

  input  wire [`SP_DATA_WIDTH-1:0]  dmem_rdata_i,   // Load data from memory
  input  wire                       dmem_ack_i,     // Memory has answered

  output logic                      dmem_req_o,     // Memory access this cycle
  output logic                      dmem_we_o,      // Write, STORE only
  output logic [`SP_DATA_WIDTH-1:0] dmem_addr_o,    // Byte address
  output logic [`SP_DATA_WIDTH-1:0] dmem_wdata_o,   // Word to store
  output logic [`SP_DATA_WIDTH-1:0] rd_data_o       // Merged result
);

  localparam int EXT_W = `SP_DATA_WIDTH - `SP_IMM_WIDTH;  // Sign extension bits

  ////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////

  logic [`SP_DATA_WIDTH-1:0] rs2_neg;   // Two's complement of rs2
  logic [`SP_DATA_WIDTH-1:0] imm_ext;   // Immediate widened to a word
  logic                      is_mem;    // LOAD or STORE

  assign rs2_neg = ~rs2_data_i + `SP_DATA_WIDTH'(1);
  assign imm_ext = {{EXT_W{imm_i[`SP_IMM_WIDTH-1]}}, imm_i};
  assign is_mem  = (func_i == LOAD) || (func_i == STORE);

  ////////////////////////////////////////////////////////////
  // Memory request
  ////////////////////////////////////////////////////////////

  assign dmem_req_o   = ex_valid_i && is_mem;   // Held func in load wait must not re-request
  assign dmem_addr_o  = rs1_data_i;             // Address from rs1
  assign dmem_wdata_o = rs2_data_i;             // Data from rs2

  ////////////////////////////////////////////////////////////
  // Result merge
  ////////////////////////////////////////////////////////////

  // Shift amounts use the full word, so 32 and above clear the result
  always_comb begin
    dmem_we_o = 1'b0;
    rd_data_o = '0;
    case (func_i)
      ADDI:  rd_data_o = rs1_data_i + imm_ext;
      ADD:   rd_data_o = rs1_data_i + rs2_data_i;
      SUB:   rd_data_o = rs1_data_i + rs2_neg;      // a + (-b)
      AND:   rd_data_o = rs1_data_i & rs2_data_i;
      OR:    rd_data_o = rs1_data_i | rs2_data_i;
      XOR:   rd_data_o = rs1_data_i ^ rs2_data_i;
      NOT:   rd_data_o = ~rs1_data_i;               // rs2 ignored
      SLL:   rd_data_o = rs1_data_i << rs2_data_i;
      SLLI:  rd_data_o = rs1_data_i << imm_ext;
      SLR:   rd_data_o = rs1_data_i >> rs2_data_i;  // Logical, zero fill
      SLRI:  rd_data_o = rs1_data_i >> imm_ext;
      LOAD: begin
        if (dmem_ack_i) begin
          rd_data_o = dmem_rdata_i;                 // Valid once memory acks
        end
      end
      STORE: begin
        dmem_we_o = 1'b1;                           // No register result
      end
      default: rd_data_o = '0;                      // Codes 13 to 15
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/data_memory.sv ====
/*
  Internal word-addressed data memory for LOAD and STORE.
  Each request is answered by a one-cycle ack; read data is registered with it.
*/

`timescale 1ns/1ps
`default_nettype none

`include "simple_processor_config.svh"

module data_memory (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       req_i,      // Access request, one cycle
  input  wire                       we_i,       // High for a write
  input  wire [`SP_DATA_WIDTH-1:0]  addr_i,     // Byte address
  input  wire [`SP_DATA_WIDTH-1:0]  wdata_i,    // Store data
  output logic [`SP_DATA_WIDTH-1:0] rdata_o,    // Registered read data
  output logic                      ack_o       // Request done, next cycle
);

  localparam int DEPTH = 1 << `SP_DMEM_ADDR_WIDTH;  // 64 words

  logic [`SP_DATA_WIDTH-1:0]     mem_q [DEPTH];     // Word storage
  logic [`SP_DMEM_ADDR_WIDTH-1:0] word_addr;        // Byte address >> 2

  // Drop the byte offset, upper bits wrap
  assign word_addr = addr_i[`SP_DMEM_ADDR_WIDTH+1:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;                            // Memory starts cleared
      end
      rdata_o <= '0;
      ack_o   <= 1'b0;
    end else begin
      ack_o <= req_i;                              // Every request acks once
      if (req_i && we_i) begin
        mem_q[word_addr] <= wdata_i;               // STORE
      end
      if (req_i && !we_i) begin
        rdata_o <= mem_q[word_addr];               // LOAD
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
/*
  Eight-entry register file with two combinational read ports and one write port.
  A read that hits the register being written returns the new data in the same cycle.
*/

`timescale 1ns/1ps
`default_nettype none

`include "simple_processor_config.svh"

module register_file
  import simple_processor_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_n_i,

  // Read ports
  input  wire reg_idx_t            rs1_idx_i,   // Index of first operand
  input  wire reg_idx_t            rs2_idx_i,   // Index of second operand
  output logic [`SP_DATA_WIDTH-1:0] rs1_data_o,
  output logic [`SP_DATA_WIDTH-1:0] rs2_data_o,

  // Write port
  input  wire                      we_i,        // Write strobe
  input  wire reg_idx_t            wr_idx_i,    // Register to update
  input  wire [`SP_DATA_WIDTH-1:0] wr_data_i    // New register value
);

  logic [`SP_DATA_WIDTH-1:0] regs_q [`SP_REG_COUNT];  // Register storage

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `SP_REG_COUNT; i++) begin
        regs_q[i] <= '0;                        // All registers start at zero
      end
    end else if (we_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read with write-through bypass
  ////////////////////////////////////////////////////////////

  // Pending write wins over the stored value
  assign rs1_data_o = (we_i && (wr_idx_i == rs1_idx_i)) ? wr_data_i : regs_q[rs1_idx_i];
  assign rs2_data_o = (we_i && (wr_idx_i == rs2_idx_i)) ? wr_data_i : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

// ==== rtl/simple_processor_pkg.sv ====
/*
  Shared types of the simple processor: function codes and register index.
  Modules pull these in by a wildcard import in their header.
*/

`default_nettype none

`include "simple_processor_config.svh"

package simple_processor_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction word, MSB first
  //   [18:15] func   function code below
  //   [14:12] rd     destination register
  //   [11:9]  rs1    first source, also the memory address
  //   [8:6]   rs2    second source, also the store data
  //   [5:0]   imm    signed immediate for ADDI, SLLI, SLRI
  ////////////////////////////////////////////////////////////

  // Codes 13 to 15 are not decoded and do nothing
  typedef enum logic [3:0] {
    ADDI  = 4'd0,
    ADD   = 4'd1,
    SUB   = 4'd2,
    AND   = 4'd3,
    OR    = 4'd4,
    XOR   = 4'd5,
    NOT   = 4'd6,
    SLL   = 4'd7,
    SLLI  = 4'd8,
    SLR   = 4'd9,
    SLRI  = 4'd10,
    LOAD  = 4'd11,
    STORE = 4'd12
  } func_t;

  typedef logic [$clog2(`SP_REG_COUNT)-1:0] reg_idx_t;  // Selects one register

endpackage

`default_nettype wire

// ==== include/simple_processor_config.svh ====
/*
  Width and depth settings for the simple processor datapath.
  Included by the package and by every module that sizes a port.
*/

`ifndef SIMPLE_PROCESSOR_CONFIG_SVH
`define SIMPLE_PROCESSOR_CONFIG_SVH

// Datapath word
`define SP_DATA_WIDTH 32        // Bits per data word and per register

// Data memory
`define SP_DMEM_ADDR_WIDTH 6    // Word address bits, 64 words

// Register file and instruction word
`define SP_REG_COUNT 8          // Architectural registers
`define SP_IMM_WIDTH 6          // Immediate field, sign extended in execute
`define SP_INSTR_WIDTH 19       // func + rd + rs1 + rs2 + imm

`endif
